//--- design/busSizer_consts.svh
/*
  Shared constants for the dynamic bus sizer
    Byte lane width
    DSACK termination codes
    CPU SIZ codes and the line transfer type
    Beats per line burst
*/
`ifndef BUS_SIZER_CONSTS_SVH
`define BUS_SIZER_CONSTS_SVH

`define LANE_W      8       // Bits per byte lane

// Port termination, DSACK[1:0]
`define DSACK_32    2'b00   // Long word port
`define DSACK_16    2'b01   // Word port
`define DSACK_NONE  2'b11   // Not acknowledged yet

// CPU transfer size, SIZ[1:0]
`define SIZ_LONG    2'b00
`define SIZ_BYTE    2'b01
`define SIZ_WORD    2'b10
`define SIZ_LINE    2'b11

`define TT_LINE     2'b01   // Transfer type of a burst
`define BURST_BEATS 4       // Long words per line

`endif

//--- design/busSizerPkg.sv
/*
  Bus sizer types
    sizerState_t  sizing FSM states
    cpuReq_t      CPU cycle descriptor
    dataLanes_t   four byte lanes, b0 most significant
*/
`include "busSizer_consts.svh"

package busSizerPkg;

    //////////////////////////////////////////////////
    // Sizing FSM states
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        stIdle  = 4'd0,     // Waiting for nTsCpu
        stLongA = 4'd1,     // Long word or line, first half
        stLongB = 4'd2,     // Second half on a word port
        stWord0 = 4'd3,     // Word at address 0
        stWord2 = 4'd4,     // Word at address 2
        stByte0 = 4'd5,
        stByte1 = 4'd6,
        stByte2 = 4'd7,
        stByte3 = 4'd8
    } sizerState_t;

    // CPU cycle descriptor, sampled with nTsCpu
    typedef struct packed {
        logic [1:0] siz;    // Transfer size
        logic [1:0] addr;   // A1..A0
        logic [1:0] tt;     // Transfer type
        logic       rnw;    // High for read
    } cpuReq_t;

    // Data bus split into byte lanes
    typedef struct packed {
        logic [`LANE_W-1:0] b0;     // D31..D24
        logic [`LANE_W-1:0] b1;     // D23..D16
        logic [`LANE_W-1:0] b2;     // D15..D8
        logic [`LANE_W-1:0] b3;     // D7..D0
    } dataLanes_t;

endpackage

//--- design/sizingControl.sv
/*
  Dynamic bus sizing FSM
    Decodes the CPU cycle into a sizing state
    Splits long words on a word port into two port cycles
    Counts line beats, stops early on nTbi
    Falling edge registers for nTs and nTa
*/
`timescale 1ns/1ns
`include "busSizer_consts.svh"

module sizingControl (
    input  logic                     BCLK,
    input  logic                     nRESET,
    input  logic                     nTsCpu,    // CPU transfer start
    input  logic                     nTbi,      // Burst inhibit
    input  logic [1:0]               dsack,     // Port termination
    input  busSizerPkg::cpuReq_t     req,
    output busSizerPkg::sizerState_t state,
    output logic                     nTs,       // Start to the port
    output logic                     nTa        // Acknowledge to the CPU
);
    import busSizerPkg::*;

    logic       startBit;       // Request a port cycle
    logic       ackBit;         // Port has terminated a beat
    logic       secondHalf;     // Word port asked for the rest of a long word
    logic       burst;          // Current cycle is a line
    logic [2:0] beatCnt;        // Line beats seen so far
    logic       tsReg;
    logic       taReg;

    //////////////////////////////////////////////////
    // Cycle FSM, rising edge
    //////////////////////////////////////////////////
    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            state      <= stIdle;
            startBit   <= 1'b0;
            ackBit     <= 1'b0;
            secondHalf <= 1'b0;
            burst      <= 1'b0;
            beatCnt    <= 3'd0;
        end else begin
            case (state)
                stIdle: begin
                    ackBit <= 1'b0;
                    if (!nTsCpu) begin
                        startBit <= 1'b1;       // nTs at next falling edge
                        case (req.siz)
                            `SIZ_LONG, `SIZ_LINE: begin
                                burst   <= (req.tt == `TT_LINE);
                                beatCnt <= 3'd0;
                                state   <= stLongA;
                            end
                            `SIZ_WORD: begin
                                burst <= 1'b0;
                                state <= req.addr[1] ? stWord2 : stWord0;  // A0 ignored
                            end
                            default: begin      // Byte
                                burst <= 1'b0;
                                case (req.addr)
                                    2'b00:   state <= stByte0;
                                    2'b01:   state <= stByte1;
                                    2'b10:   state <= stByte2;
                                    default: state <= stByte3;
                                endcase
                            end
                        endcase
                    end
                end

                stLongA: begin
                    startBit <= 1'b0;
                    case (dsack)
                        `DSACK_32: begin
                            ackBit <= 1'b1;
                            if (burst && !ackBit) begin
                                beatCnt <= beatCnt + 3'd1;  // Once per beat
                            end
                        end
                        `DSACK_16: begin
                            // Second port cycle instead of nTa
                            if (!secondHalf) begin
                                startBit <= 1'b1;
                            end
                            secondHalf <= 1'b1;
                        end
                        `DSACK_NONE: begin
                            if (secondHalf) begin
                                secondHalf <= 1'b0;
                                state      <= stLongB;
                            end else if (ackBit) begin
                                ackBit <= 1'b0;     // End of beat
                                if (!burst || !nTbi || beatCnt == 3'(`BURST_BEATS)) begin
                                    state <= stIdle;
                                end
                            end
                        end
                        default: ;                  // Reserved code, wait
                    endcase
                end

                default: begin
                    // Single beat states and the second long word half
                    startBit <= 1'b0;
                    if (dsack != `DSACK_NONE) begin
                        ackBit <= 1'b1;
                    end else if (ackBit) begin
                        ackBit <= 1'b0;
                        state  <= stIdle;
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Strobe outputs, falling edge
    //////////////////////////////////////////////////
    always_ff @(negedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            tsReg <= 1'b0;
            taReg <= 1'b0;
        end else begin
            tsReg <= startBit;      // Half clock after the FSM
            taReg <= ackBit;
        end
    end

    assign nTs = ~tsReg;    // Active low strobes
    assign nTa = ~taReg;

endmodule

//--- design/writeLaneSteer.sv
/*
  Write data steering
    Places CPU write bytes onto the port lanes per sizing state
    Word ports find the addressed bytes on lanes 0 and 1
*/
`timescale 1ns/1ns

module writeLaneSteer (
    input  busSizerPkg::sizerState_t state,
    input  busSizerPkg::dataLanes_t  cpuDataIn,
    output busSizerPkg::dataLanes_t  portDataOut
);
    import busSizerPkg::*;

    // Live path, no registers on writes
    always_comb begin
        portDataOut = cpuDataIn;                // Lanes pass straight by default
        case (state)
            stIdle: begin
                portDataOut = '0;
            end
            stLongB, stWord2: begin
                portDataOut.b0 = cpuDataIn.b2;  // Low word onto the upper lanes
                portDataOut.b1 = cpuDataIn.b3;
            end
            stByte1: begin
                portDataOut.b0 = cpuDataIn.b1;
            end
            stByte2: begin
                portDataOut.b0 = cpuDataIn.b2;
            end
            stByte3: begin
                // Byte 3 on every lane
                portDataOut.b0 = cpuDataIn.b3;
                portDataOut.b1 = cpuDataIn.b3;
                portDataOut.b2 = cpuDataIn.b3;
            end
            default: ;      // stLongA, stWord0, stByte0 straight
        endcase
    end

endmodule

//--- design/readLaneLatch.sv
/*
  Read data capture
    Registers port lanes into CPU lanes on each DSACK edge
    Assembles long words from two word port cycles
    Holds the last read between cycles
*/
`timescale 1ns/1ns
`include "busSizer_consts.svh"

module readLaneLatch (
    input  logic                     BCLK,
    input  logic                     nRESET,
    input  busSizerPkg::sizerState_t state,
    input  logic [1:0]               dsack,
    input  busSizerPkg::dataLanes_t  portDataIn,
    output busSizerPkg::dataLanes_t  cpuDataOut
);
    import busSizerPkg::*;

    logic capture;

    assign capture = (dsack != `DSACK_NONE);    // Any port termination

    //////////////////////////////////////////////////
    // Lane capture
    //////////////////////////////////////////////////
    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            cpuDataOut <= '0;
        end else if (capture) begin
            case (state)
                stLongA: begin
                    if (dsack == `DSACK_32) begin
                        cpuDataOut <= portDataIn;           // Whole long word
                    end else if (dsack == `DSACK_16) begin
                        cpuDataOut.b0 <= portDataIn.b0;     // High word first
                        cpuDataOut.b1 <= portDataIn.b1;
                    end
                end
                stLongB: begin
                    // Low word arrives on the upper lanes
                    cpuDataOut.b2 <= portDataIn.b0;
                    cpuDataOut.b3 <= portDataIn.b1;
                end
                stWord0, stByte0: begin
                    cpuDataOut <= portDataIn;
                end
                stWord2: begin
                    cpuDataOut.b0 <= portDataIn.b2;         // Duplicated onto both halves
                    cpuDataOut.b1 <= portDataIn.b3;
                    cpuDataOut.b2 <= portDataIn.b2;
                    cpuDataOut.b3 <= portDataIn.b3;
                end
                stByte1: begin
                    cpuDataOut    <= portDataIn;
                    cpuDataOut.b0 <= portDataIn.b1;         // Addressed lane to byte 0
                end
                stByte2: begin
                    cpuDataOut    <= portDataIn;
                    cpuDataOut.b0 <= portDataIn.b2;
                end
                stByte3: begin
                    cpuDataOut    <= portDataIn;
                    cpuDataOut.b0 <= portDataIn.b3;
                end
                default: ;                                  // Idle, hold
            endcase
        end
    end

endmodule

//--- design/busSizerTop.sv
/*
  Bus sizer top level
    Packs the CPU cycle descriptor
    Sizing FSM, write steering and read capture
    Output enables for the split CPU and port buses
*/
`timescale 1ns/1ns

module busSizerTop (
    input  logic                    BCLK,
    input  logic                    nRESET,
    input  logic                    nTsCpu,
    input  logic                    nTbi,
    input  logic                    rnw,
    input  logic                    nBg,        // Bus grant
    input  logic [1:0]              siz,
    input  logic [1:0]              addr,
    input  logic [1:0]              tt,
    input  logic [1:0]              dsack,
    input  busSizerPkg::dataLanes_t cpuDataIn,
    input  busSizerPkg::dataLanes_t portDataIn,
    output logic                    nTs,
    output logic                    nTa,
    output busSizerPkg::dataLanes_t cpuDataOut,
    output busSizerPkg::dataLanes_t portDataOut,
    output logic                    cpuOe,
    output logic                    portOe
);
    import busSizerPkg::*;

    cpuReq_t     req;
    sizerState_t state;

    // CPU cycle descriptor
    assign req.siz  = siz;
    assign req.addr = addr;
    assign req.tt   = tt;
    assign req.rnw  = rnw;

    //////////////////////////////////////////////////
    // Sizing blocks
    //////////////////////////////////////////////////
    sizingControl ctrl_i (
        .BCLK   (BCLK),
        .nRESET (nRESET),
        .nTsCpu (nTsCpu),
        .nTbi   (nTbi),
        .dsack  (dsack),
        .req    (req),
        .state  (state),
        .nTs    (nTs),
        .nTa    (nTa)
    );

    writeLaneSteer steer_i (
        .state       (state),
        .cpuDataIn   (cpuDataIn),
        .portDataOut (portDataOut)
    );

    readLaneLatch latch_i (
        .BCLK       (BCLK),
        .nRESET     (nRESET),
        .state      (state),
        .dsack      (dsack),
        .portDataIn (portDataIn),
        .cpuDataOut (cpuDataOut)
    );

    // Port side drives on writes, CPU side on reads
    assign portOe = ~req.rnw & ~nBg & nRESET;
    assign cpuOe  = req.rnw & ~nBg;

endmodule

//--- test/portModel.sv
/*
  Behavioral target port
    Answers nTs with DSACK as a 16 or 32 bit port
    Serves read words in order within one CPU cycle
    Captures the write lanes on each termination
*/
`timescale 1ns/1ns
`include "busSizer_consts.svh"

module portModel (
    input  logic                    BCLK,
    input  logic                    nTsCpu,         // Restarts the word order
    input  logic                    nTs,
    input  logic                    wide16,         // Word port when high
    input  int                      beats,          // Terminations per nTs
    input  busSizerPkg::dataLanes_t readWords [4],
    input  busSizerPkg::dataLanes_t writeData,
    output logic [1:0]              dsack,
    output busSizerPkg::dataLanes_t readData,
    output busSizerPkg::dataLanes_t lastWrite
);
    import busSizerPkg::*;

    logic [1:0] idx;    // Next read word
    int         k;

    initial begin
        dsack     = `DSACK_NONE;
        readData  = '0;
        lastWrite = '0;
        idx       = 2'd0;
        forever begin
            @(posedge BCLK);
            if (!nTsCpu) begin
                idx = 2'd0;                             // New CPU cycle
            end
            if (!nTs) begin
                for (k = 0; k < beats; k++) begin
                    #5;
                    readData  = readWords[idx];
                    lastWrite = writeData;              // Live write lanes
                    dsack     = wide16 ? `DSACK_16 : `DSACK_32;
                    idx       = idx + 2'd1;
                    @(posedge BCLK);                    // Held for one clock
                    #5;
                    dsack = `DSACK_NONE;
                    if (k < beats - 1) begin
                        @(posedge BCLK);                // Gap between line beats
                    end
                end
            end
        end
    end

endmodule

//--- test/busSizerTb.sv
/*
  Bus sizer testbench
    Clock, reset and CPU cycle tasks
    Expected lanes from the sizing rules
    Port model as a 16 or 32 bit target
*/
`timescale 1ns/1ns
`include "busSizer_consts.svh"

module busSizerTb;
    import busSizerPkg::*;

    logic       BCLK = 1'b0;
    logic       nRESET, nTsCpu, nTbi, rnw, nBg;
    logic       nTs, nTa, cpuOe, portOe;
    logic [1:0] siz, addr, tt, dsack;
    logic       wide16;                         // Port width select
    int         beats;
    int         seed = 32'h390b_410c;
    dataLanes_t cpuDataIn, portDataIn, cpuDataOut, portDataOut, lastWrite;
    dataLanes_t readWords [4];                  // Port read data per beat

    always #50 BCLK = ~BCLK;                    // 100 ns clock

    busSizerTop dut_i (.*);

    portModel port_i (
        .BCLK, .nTsCpu, .nTs, .wide16, .beats, .readWords,
        .writeData (portDataOut), .dsack, .readData (portDataIn), .lastWrite
    );

    // Lanes the CPU side or port side should show for one cycle
    function automatic dataLanes_t expectLanes(input logic r, input logic [1:0] s,
                                               input logic [1:0] a, input dataLanes_t w);
        logic [7:0] l [4];
        dataLanes_t e;
        l[0] = w.b0;
        l[1] = w.b1;
        l[2] = w.b2;
        l[3] = w.b3;
        e = w;                                  // Long, word 0, byte 0 straight
        if (s == `SIZ_WORD && a[1]) begin
            e = {w.b2, w.b3, w.b2, w.b3};       // Low word on both halves
        end else if (s == `SIZ_BYTE && !r && a == 2'd3) begin
            e = {4{w.b3}};                      // Write byte 3 on every lane
        end else if (s == `SIZ_BYTE) begin
            e.b0 = l[a];                        // Addressed byte in lane 0
        end
        return e;
    endfunction

    task automatic stopWithError(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else stopWithError($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    // New request a clock ahead of nTsCpu, fresh data, default port
    task automatic driveRequest(input logic r, input logic [1:0] s,
                                input logic [1:0] a, input logic [1:0] t);
        logic [2:0] k;
        @(posedge BCLK);
        #5;
        rnw       = r;
        siz       = s;
        addr      = a;
        tt        = t;
        nTbi      = 1'b1;
        wide16    = 1'b0;
        beats     = 1;
        cpuDataIn = $random(seed);
        for (k = 3'd0; k < 3'd4; k++) begin
            readWords[k[1:0]] = $random(seed);
        end
    endtask

    //////////////////////////////////////////////////
    // One CPU cycle, strobes counted at each falling edge
    //////////////////////////////////////////////////
    task automatic runCycle(input string name, input int expTs, input int expTa,
                            input dataLanes_t expData);
        int   n;
        int   tail;
        int   tsPulses;
        int   taPulses;
        logic prevTs;
        logic prevTa;
        logic checked;
        tail     = 0;
        tsPulses = 0;
        taPulses = 0;
        prevTs   = 1'b1;
        prevTa   = 1'b1;
        checked  = 1'b0;
        @(posedge BCLK);
        #5;
        nTsCpu = 1'b0;
        @(posedge BCLK);
        #5;
        nTsCpu = 1'b1;                          // One clock start
        for (n = 0; n < 40 && tail < 3; n++) begin
            @(negedge BCLK);
            #1;
            tsPulses += (!nTs && prevTs) ? 1 : 0;
            taPulses += (!nTa && prevTa) ? 1 : 0;
            // Read data while nTa is low, write lanes while nTs is low
            if (!checked && ((rnw && !nTa) || (!rnw && !nTs))) begin
                checked = 1'b1;
                checkEq({name, " data"}, expData, rnw ? cpuDataOut : portDataOut);
                checkEq({name, " oe"}, {30'd0, rnw, !rnw}, {30'd0, cpuOe, portOe});
            end
            prevTs = nTs;
            prevTa = nTa;
            tail   = (taPulses == expTa && nTa) ? tail + 1 : 0;   // Quiet clocks after the end
        end
        if (tail < 3) begin
            stopWithError({"Timeout: ", name, " did not finish within 40 clocks"});
        end
        checkEq({name, " nTs pulses"}, expTs, tsPulses);
        checkEq({name, " nTa pulses"}, expTa, taPulses);
    endtask

    initial begin
        int r;
        int a;
        nRESET    = 1'b0;
        nTsCpu    = 1'b1;
        nTbi      = 1'b1;
        rnw       = 1'b0;                       // Write with grant, oe held off by reset
        nBg       = 1'b0;
        siz       = `SIZ_LONG;
        addr      = 2'd0;
        tt        = 2'd0;
        wide16    = 1'b0;
        beats     = 1;
        cpuDataIn = '0;
        readWords = '{default: '0};
        repeat (2) @(posedge BCLK);
        #5;
        checkEq("in reset strobes oe", 32'h6, {29'd0, nTs, nTa, portOe});
        checkEq("in reset cpuDataOut", 32'h0, cpuDataOut);
        repeat (3) @(posedge BCLK);
        #5;
        nRESET = 1'b1;
        rnw    = 1'b1;
        @(negedge BCLK);
        #1;
        checkEq("after reset strobes oe", 32'h6, {29'd0, nTs, nTa, portOe});
        checkEq("after reset cpuDataOut", 32'h0, cpuDataOut);

        //////////////////////////////////////////////////
        // Long words on both port widths
        //////////////////////////////////////////////////
        driveRequest(1'b1, `SIZ_LONG, 2'd0, 2'd0);
        runCycle("long read 32", 1, 1, readWords[0]);
        driveRequest(1'b1, `SIZ_LONG, 2'd0, 2'd0);
        wide16 = 1'b1;
        runCycle("long read 16", 2, 1,
                 {readWords[0].b0, readWords[0].b1, readWords[1].b0, readWords[1].b1});
        driveRequest(1'b0, `SIZ_LONG, 2'd0, 2'd0);
        runCycle("long write", 1, 1, cpuDataIn);
        checkEq("long write at port", cpuDataIn, lastWrite);
        driveRequest(1'b0, `SIZ_LONG, 2'd0, 2'd0);
        wide16 = 1'b1;
        runCycle("long write 16", 2, 1, cpuDataIn);
        // Second half puts CPU bytes 2 and 3 on lanes 0 and 1
        checkEq("long write 16 at port",
                {cpuDataIn.b2, cpuDataIn.b3, cpuDataIn.b2, cpuDataIn.b3}, lastWrite);

        // Words at 0 and 2, then bytes at 0 to 3, reads before writes
        for (r = 1; r >= 0; r--) begin
            for (a = 0; a < 6; a++) begin
                driveRequest(r[0], a < 2 ? `SIZ_WORD : `SIZ_BYTE,
                             a < 2 ? 2'(a * 2) : 2'(a - 2), 2'd0);
                runCycle($sformatf("rnw %0d siz %0d addr %0d", rnw, siz, addr), 1, 1,
                         expectLanes(rnw, siz, addr, rnw ? readWords[0] : cpuDataIn));
            end
        end

        // Bus not granted, neither side drives
        for (r = 0; r < 2; r++) begin
            driveRequest(r[0], `SIZ_LONG, 2'd0, 2'd0);
            nBg = 1'b1;
            @(negedge BCLK);
            #1;
            checkEq($sformatf("no grant oe rnw %0d", r), 32'h0, {30'd0, cpuOe, portOe});
        end
        @(posedge BCLK);
        #5;
        nBg = 1'b0;

        //////////////////////////////////////////////////
        // Line reads, full and inhibited
        //////////////////////////////////////////////////
        driveRequest(1'b1, `SIZ_LINE, 2'd0, `TT_LINE);
        beats = `BURST_BEATS;
        runCycle("line read", 1, `BURST_BEATS, readWords[0]);
        driveRequest(1'b1, `SIZ_LINE, 2'd0, `TT_LINE);
        beats = `BURST_BEATS;                   // Port keeps bursting, the sizer has to stop
        nTbi  = 1'b0;
        runCycle("line read inhibited", 1, 1, readWords[0]);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- all.f
+incdir+design
design/busSizerPkg.sv
design/sizingControl.sv
design/writeLaneSteer.sv
design/readLaneLatch.sv
design/busSizerTop.sv
test/portModel.sv
test/busSizerTb.sv

//--- run.sh
#!/bin/sh
# Build the bus sizer testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ns --top-module busSizerTb \
    -f all.f -o busSizerSim &&
./obj_dir/busSizerSim ||
{ echo "simulation failed"; exit 1; }
